// File: rtl/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// load/store queue depth
`define LSQ_N_ENTRIES 8

// buffers between issue and the data cache
`define LDB_N_ENTRIES 4
// must stay a power of two for the wrap-bit pointers
`define ST_BUF_N_ENTRIES 4

// ROB tag width
`define ROB_ID_WIDTH 6

// datapath widths
`define REG_DATA_WIDTH 32
`define ADDR_WIDTH 32

`endif

// File: rtl/lsu_pkg.sv
`default_nettype none
`include "lsu_defines.svh"

package lsu_pkg;

    typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t;
    typedef logic [`REG_DATA_WIDTH-1:0] reg_data_t;
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_width_e;

    // operands that are not ready carry their producer tag
    typedef struct packed {
        logic       ld_st;
        mem_width_e width;
        reg_data_t  imm;
        rob_id_t    instr_rob_id;
        logic       base_addr_ready;
        addr_t      base_addr;
        rob_id_t    base_rob_id;
        logic       st_data_ready;
        reg_data_t  st_data;
        rob_id_t    st_data_rob_id;
    } lsq_dispatch_t;

    typedef struct packed {
        logic          valid;
        lsq_dispatch_t instr;
    } lsq_entry_t;

    typedef struct packed {
        addr_t      eff_addr;
        mem_width_e ld_width;
        rob_id_t    instr_rob_id;
    } ld_buf_entry_t;

    typedef struct packed {
        addr_t      eff_addr;
        mem_width_e st_width;
        reg_data_t  st_data;
        rob_id_t    instr_rob_id;
    } st_buf_entry_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        reg_data_t reg_data;
    } broadcast_t;

endpackage

`default_nettype wire

// File: rtl/lsq_shift_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module lsq_shift_queue (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  flush,

    input  wire logic                  enq_valid,
    input  wire lsu_pkg::lsq_dispatch_t enq_data,
    output logic                       enq_ready,

    input  wire lsu_pkg::broadcast_t   alu_broadcast,
    input  wire lsu_pkg::broadcast_t   ld_broadcast,

    input  wire logic                  deq_ready,
    output logic                       sched_valid,
    output lsu_pkg::lsq_entry_t        sched_entry
);
    import lsu_pkg::*;

    localparam int N = `LSQ_N_ENTRIES;
    localparam int IDX_W = $clog2(N);
    localparam int CNT_W = $clog2(N + 1);

    lsq_entry_t [N-1:0] entries;
    // one extra empty slot shifts in at the top
    lsq_entry_t [N:0]   woken;
    lsq_entry_t [N-1:0] entries_nxt;
    lsq_dispatch_t      enq_woken;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   enq_pos;
    logic [N-1:0]       ready;
    logic [IDX_W-1:0]   sched_idx;
    logic               enq_fire;

    // tag match against both result buses
    function automatic lsq_dispatch_t capture(input lsq_dispatch_t d,
                                              input broadcast_t alu,
                                              input broadcast_t ld);
        lsq_dispatch_t r;
        r = d;
        if (!d.base_addr_ready) begin
            if (alu.valid && alu.rob_id == d.base_rob_id) begin
                r.base_addr_ready = 1'b1;
                r.base_addr = alu.reg_data;
            end else if (ld.valid && ld.rob_id == d.base_rob_id) begin
                r.base_addr_ready = 1'b1;
                r.base_addr = ld.reg_data;
            end
        end
        if (!d.st_data_ready) begin
            if (alu.valid && alu.rob_id == d.st_data_rob_id) begin
                r.st_data_ready = 1'b1;
                r.st_data = alu.reg_data;
            end else if (ld.valid && ld.rob_id == d.st_data_rob_id) begin
                r.st_data_ready = 1'b1;
                r.st_data = ld.reg_data;
            end
        end
        return r;
    endfunction

    assign enq_ready = (count != CNT_W'(N));
    assign enq_fire  = enq_valid && enq_ready;
    // dequeued slot frees up before the new entry lands
    assign enq_pos   = count - CNT_W'(deq_ready);
    assign enq_woken = capture(enq_data, alu_broadcast, ld_broadcast);

    always_comb begin
        for (int i = 0; i < N; i++) begin
            ready[i] = entries[i].valid && entries[i].instr.base_addr_ready
                    && (!entries[i].instr.ld_st || entries[i].instr.st_data_ready);
        end
    end

    // lowest index is the oldest
    always_comb begin
        sched_idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sched_idx = IDX_W'(i);
            end
        end
    end

    assign sched_valid = |ready;
    assign sched_entry = entries[sched_idx];

    always_comb begin
        for (int i = 0; i < N; i++) begin
            woken[i].valid = entries[i].valid;
            woken[i].instr = capture(entries[i].instr, alu_broadcast, ld_broadcast);
        end
        woken[N] = '0;
    end

    // collapse above the dequeued slot, append at the tail
    always_comb begin
        for (int i = 0; i < N; i++) begin
            if (deq_ready && IDX_W'(i) >= sched_idx) begin
                entries_nxt[i] = woken[i+1];
            end else begin
                entries_nxt[i] = woken[i];
            end
            if (enq_fire && CNT_W'(i) == enq_pos) begin
                entries_nxt[i].valid = 1'b1;
                entries_nxt[i].instr = enq_woken;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            count <= '0;
            for (int i = 0; i < N; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            count <= count + CNT_W'(enq_fire) - CNT_W'(deq_ready);
            entries <= entries_nxt;
        end
    end

    // issue logic may only take an entry that was offered
    a_deq_needs_sched: assert property (@(posedge clk) disable iff (!rst_n)
        deq_ready |-> sched_valid);

    // count and valid bits agree, so the top slot is free on accept
    a_no_enq_full: assert property (@(posedge clk) disable iff (!rst_n)
        enq_fire |-> !entries[N-1].valid);

endmodule

`default_nettype wire

// File: rtl/load_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module load_buffer (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   flush,

    input  wire logic                   enq_valid,
    input  wire lsu_pkg::ld_buf_entry_t enq_data,
    output logic                        enq_ready,

    output logic                        req_valid,
    output lsu_pkg::ld_buf_entry_t      req,
    input  wire logic                   req_ready
);
    import lsu_pkg::*;

    localparam int N = `LDB_N_ENTRIES;
    localparam int CNT_W = $clog2(N + 1);

    ld_buf_entry_t [N-1:0] entries;
    logic [CNT_W-1:0]      count;
    logic [CNT_W-1:0]      enq_pos;
    logic                  enq_fire;
    logic                  deq_fire;

    assign enq_ready = (count != CNT_W'(N));
    assign req_valid = (count != '0);
    // oldest load always sits in slot 0
    assign req       = entries[0];

    assign enq_fire = enq_valid && enq_ready;
    assign deq_fire = req_valid && req_ready;
    assign enq_pos  = count - CNT_W'(deq_fire);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(enq_fire) - CNT_W'(deq_fire);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N - 1; i++) begin
            if (enq_fire && enq_pos == CNT_W'(i)) begin
                entries[i] <= enq_data;
            end else if (deq_fire) begin
                entries[i] <= entries[i+1];
            end
        end
        if (enq_fire && enq_pos == CNT_W'(N - 1)) begin
            entries[N-1] <= enq_data;
        end
    end

    // issue logic must respect enq_ready
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        enq_valid |-> enq_ready);

endmodule

`default_nettype wire

// File: rtl/store_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module store_buffer (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   flush,

    input  wire logic                   enq_valid,
    input  wire lsu_pkg::st_buf_entry_t enq_data,
    output logic                        enq_ready,

    output logic                        req_valid,
    output lsu_pkg::st_buf_entry_t      req,
    input  wire logic                   req_ready
);
    import lsu_pkg::*;

    localparam int N = `ST_BUF_N_ENTRIES;
    localparam int PTR_W = $clog2(N);

    st_buf_entry_t  mem [N];
    // msb is the wrap bit
    logic [PTR_W:0] head;
    logic [PTR_W:0] tail;
    logic [PTR_W:0] occupancy;
    logic           empty;
    logic           full;
    logic           enq_fire;
    logic           deq_fire;

    assign empty = (head == tail);
    assign full  = (head[PTR_W] != tail[PTR_W])
                && (head[PTR_W-1:0] == tail[PTR_W-1:0]);
    assign occupancy = tail - head;

    assign enq_ready = !full;
    assign req_valid = !empty;
    assign req       = mem[head[PTR_W-1:0]];

    assign enq_fire = enq_valid && enq_ready;
    assign deq_fire = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (enq_fire) begin
                tail <= tail + 1'b1;
            end
            if (deq_fire) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[tail[PTR_W-1:0]] <= enq_data;
        end
    end

    // head never passes tail, so nothing drains from an empty FIFO
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        occupancy <= (PTR_W+1)'(N));

endmodule

`default_nettype wire

// File: rtl/load_store_issue.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module load_store_issue (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire logic                   dispatch_valid,
    input  wire lsu_pkg::lsq_dispatch_t dispatch_data,
    output logic                        dispatch_ready,

    input  wire lsu_pkg::broadcast_t    alu_broadcast,
    input  wire lsu_pkg::broadcast_t    ld_broadcast,

    input  wire logic                   fetch_redirect_valid,

    output logic                        ld_req_valid,
    output lsu_pkg::ld_buf_entry_t      ld_req,
    input  wire logic                   ld_req_ready,

    output logic                        st_req_valid,
    output lsu_pkg::st_buf_entry_t      st_req,
    input  wire logic                   st_req_ready
);
    import lsu_pkg::*;

    lsq_entry_t    sched_entry;
    logic          sched_valid;
    logic          is_store;
    logic          issue;
    addr_t         eff_addr_raw;
    addr_t         eff_addr;
    ld_buf_entry_t ld_enq_data;
    st_buf_entry_t st_enq_data;
    logic          ld_enq_valid;
    logic          ld_enq_ready;
    logic          st_enq_valid;
    logic          st_enq_ready;

    lsq_shift_queue lsq (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (fetch_redirect_valid),
        .enq_valid    (dispatch_valid),
        .enq_data     (dispatch_data),
        .enq_ready    (dispatch_ready),
        .alu_broadcast(alu_broadcast),
        .ld_broadcast (ld_broadcast),
        .deq_ready    (issue),
        .sched_valid  (sched_valid),
        .sched_entry  (sched_entry)
    );

    // agu
    assign eff_addr_raw = sched_entry.instr.base_addr + sched_entry.instr.imm;

    always_comb begin
        case (sched_entry.instr.width)
            MEM_WORD: eff_addr = {eff_addr_raw[`ADDR_WIDTH-1:2], 2'b00};
            MEM_HALF: eff_addr = {eff_addr_raw[`ADDR_WIDTH-1:1], 1'b0};
            default:  eff_addr = eff_addr_raw;
        endcase
    end

    // oldest ready entry goes only if its buffer has room
    assign is_store     = sched_entry.instr.ld_st;
    assign issue        = sched_valid && (is_store ? st_enq_ready : ld_enq_ready);
    assign ld_enq_valid = issue && !is_store;
    assign st_enq_valid = issue && is_store;

    assign ld_enq_data.eff_addr     = eff_addr;
    assign ld_enq_data.ld_width     = sched_entry.instr.width;
    assign ld_enq_data.instr_rob_id = sched_entry.instr.instr_rob_id;

    assign st_enq_data.eff_addr     = eff_addr;
    assign st_enq_data.st_width     = sched_entry.instr.width;
    assign st_enq_data.st_data      = sched_entry.instr.st_data;
    assign st_enq_data.instr_rob_id = sched_entry.instr.instr_rob_id;

    load_buffer ld_buf (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (fetch_redirect_valid),
        .enq_valid(ld_enq_valid),
        .enq_data (ld_enq_data),
        .enq_ready(ld_enq_ready),
        .req_valid(ld_req_valid),
        .req      (ld_req),
        .req_ready(ld_req_ready)
    );

    store_buffer st_buf (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (fetch_redirect_valid),
        .enq_valid(st_enq_valid),
        .enq_data (st_enq_data),
        .enq_ready(st_enq_ready),
        .req_valid(st_req_valid),
        .req      (st_req),
        .req_ready(st_req_ready)
    );

endmodule

`default_nettype wire

// File: dv/load_store_issue_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_defines.svh"

module load_store_issue_tb;
    import lsu_pkg::*;

    localparam int N_CYCLES      = 4000;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int N_TAGS        = 1 << `ROB_ID_WIDTH;
    // instruction tags use 0..31, producer tags 32..39
    localparam int PROD_BASE     = 32;

    logic          clk;
    logic          rst_n;
    logic          dispatch_valid;
    lsq_dispatch_t dispatch_data;
    logic          dispatch_ready;
    broadcast_t    alu_broadcast;
    broadcast_t    ld_broadcast;
    logic          fetch_redirect_valid;
    logic          ld_req_valid;
    ld_buf_entry_t ld_req;
    logic          ld_req_ready;
    logic          st_req_valid;
    st_buf_entry_t st_req;
    logic          st_req_ready;

    // reference model, indexed by instruction tag
    logic       m_valid    [N_TAGS];
    logic       m_in_queue [N_TAGS];
    logic       m_store    [N_TAGS];
    mem_width_e m_width    [N_TAGS];
    reg_data_t  m_imm      [N_TAGS];
    logic       m_base_rdy [N_TAGS];
    addr_t      m_base     [N_TAGS];
    rob_id_t    m_base_tag [N_TAGS];
    logic       m_data_rdy [N_TAGS];
    reg_data_t  m_data     [N_TAGS];
    rob_id_t    m_data_tag [N_TAGS];
    rob_id_t    ld_order[$];
    rob_id_t    st_order[$];

    int   seed;
    int   value_errors;
    int   other_errors;
    int   next_tag;
    int   ld_hold;
    int   st_hold;
    int   wait_cycles;
    logic disp_taken;
    logic flush_prev;

    load_store_issue load_store_issue_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .dispatch_valid      (dispatch_valid),
        .dispatch_data       (dispatch_data),
        .dispatch_ready      (dispatch_ready),
        .alu_broadcast       (alu_broadcast),
        .ld_broadcast        (ld_broadcast),
        .fetch_redirect_valid(fetch_redirect_valid),
        .ld_req_valid        (ld_req_valid),
        .ld_req              (ld_req),
        .ld_req_ready        (ld_req_ready),
        .st_req_valid        (st_req_valid),
        .st_req              (st_req),
        .st_req_ready        (st_req_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int urand(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic addr_t aligned_addr(input addr_t base, input reg_data_t imm,
                                           input mem_width_e w);
        addr_t sum;
        sum = base + imm;
        case (w)
            MEM_WORD: return sum & ~addr_t'(3);
            MEM_HALF: return sum & ~addr_t'(1);
            default:  return sum;
        endcase
    endfunction

    function automatic logic operands_ready(input rob_id_t t);
        return m_base_rdy[t] && (!m_store[t] || m_data_rdy[t]);
    endfunction

    function automatic int model_count(input logic queued_only);
        int n;
        n = 0;
        for (int t = 0; t < N_TAGS; t++) begin
            if (m_valid[t] && (!queued_only || m_in_queue[t])) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_cond(input logic ok, input string what);
        assert (ok) else begin
            other_errors++;
            $display("Failure at %0t: %s", $time, what);
        end
    endtask

    task automatic clear_model();
        for (int t = 0; t < N_TAGS; t++) begin
            m_valid[t] = 1'b0;
            m_in_queue[t] = 1'b0;
        end
        ld_order.delete();
        st_order.delete();
    endtask

    task automatic add_dispatch(input lsq_dispatch_t d);
        rob_id_t t;
        t = d.instr_rob_id;
        m_valid[t] = 1'b1;
        m_in_queue[t] = 1'b1;
        m_store[t] = d.ld_st;
        m_width[t] = d.width;
        m_imm[t] = d.imm;
        m_base_rdy[t] = d.base_addr_ready;
        m_base[t] = d.base_addr;
        m_base_tag[t] = d.base_rob_id;
        m_data_rdy[t] = d.st_data_ready;
        m_data[t] = d.st_data;
        m_data_tag[t] = d.st_data_rob_id;
    endtask

    task automatic apply_broadcast(input broadcast_t b);
        for (int t = 0; t < N_TAGS; t++) begin
            if (b.valid && m_valid[t] && m_in_queue[t]) begin
                if (!m_base_rdy[t] && m_base_tag[t] == b.rob_id) begin
                    m_base_rdy[t] = 1'b1;
                    m_base[t] = b.reg_data;
                end
                if (!m_data_rdy[t] && m_data_tag[t] == b.rob_id) begin
                    m_data_rdy[t] = 1'b1;
                    m_data[t] = b.reg_data;
                end
            end
        end
    endtask

    // entry leaving the queue for a buffer
    task automatic note_issue(input logic is_store, input rob_id_t t);
        check_cond(m_valid[t] && m_in_queue[t] && m_store[t] == is_store,
                   $sformatf("issued tag %0d is not a waiting entry of that kind", t));
        check_cond(operands_ready(t),
                   $sformatf("tag %0d issued before its operands resolved", t));
        m_in_queue[t] = 1'b0;
        if (is_store) begin
            st_order.push_back(t);
        end else begin
            ld_order.push_back(t);
        end
    endtask

    task automatic check_request(input logic is_store, input rob_id_t t, input mem_width_e w,
                                 input addr_t a, input reg_data_t d);
        string   port;
        logic    have_order;
        rob_id_t exp_tag;
        port = is_store ? "st_req" : "ld_req";
        have_order = is_store ? (st_order.size() > 0) : (ld_order.size() > 0);
        check_cond(have_order, {port, " fired with nothing issued to its buffer"});
        if (have_order) begin
            if (is_store) begin
                exp_tag = st_order.pop_front();
            end else begin
                exp_tag = ld_order.pop_front();
            end
            check_value({port, ".instr_rob_id"}, t, exp_tag);
        end
        check_cond(m_valid[t] && m_store[t] == is_store,
                   $sformatf("%s carries tag %0d, which is not outstanding", port, t));
        if (m_valid[t]) begin
            check_cond(operands_ready(t),
                       $sformatf("%s tag %0d went out with unresolved operands", port, t));
            check_value({port, is_store ? ".st_width" : ".ld_width"}, w, m_width[t]);
            check_value({port, ".eff_addr"}, a,
                        aligned_addr(m_base[t], m_imm[t], m_width[t]));
            if (is_store) begin
                check_value("st_req.st_data", d, m_data[t]);
            end
            m_valid[t] = 1'b0;
        end
    endtask

    // sample mid-cycle, predicting what the next rising edge does
    always @(negedge clk) begin
        if (rst_n !== 1'b1) begin
            clear_model();
            flush_prev = 1'b1;
            disp_taken = 1'b0;
        end else begin
            if (flush_prev) begin
                check_value("ld_req_valid", ld_req_valid, 0);
                check_value("st_req_valid", st_req_valid, 0);
            end
            check_value("dispatch_ready", dispatch_ready,
                        model_count(1'b1) < `LSQ_N_ENTRIES);
            if (ld_req_valid && ld_req_ready) begin
                check_request(1'b0, ld_req.instr_rob_id, ld_req.ld_width, ld_req.eff_addr, '0);
            end
            if (st_req_valid && st_req_ready) begin
                check_request(1'b1, st_req.instr_rob_id, st_req.st_width, st_req.eff_addr,
                              st_req.st_data);
            end
            if (load_store_issue_i.ld_enq_valid) begin
                note_issue(1'b0, load_store_issue_i.ld_enq_data.instr_rob_id);
            end
            if (load_store_issue_i.st_enq_valid) begin
                note_issue(1'b1, load_store_issue_i.st_enq_data.instr_rob_id);
            end
            disp_taken = dispatch_valid && dispatch_ready;
            if (fetch_redirect_valid) begin
                clear_model();
            end else begin
                if (disp_taken) begin
                    add_dispatch(dispatch_data);
                end
                apply_broadcast(alu_broadcast);
                apply_broadcast(ld_broadcast);
            end
            flush_prev = fetch_redirect_valid;
        end
    end

    task automatic new_dispatch();
        int  cand;
        logic found;
        found = 1'b0;
        cand = 0;
        for (int k = 0; k < 32; k++) begin
            if (!found && !m_valid[(next_tag + k) % 32]) begin
                cand = (next_tag + k) % 32;
                found = 1'b1;
            end
        end
        dispatch_valid = found && (urand(10) < 6);
        if (dispatch_valid) begin
            next_tag = (cand + 1) % 32;
        end
        dispatch_data.ld_st = urand(2);
        dispatch_data.width = mem_width_e'(urand(3));
        dispatch_data.imm = $random(seed);
        dispatch_data.instr_rob_id = rob_id_t'(cand);
        dispatch_data.base_addr_ready = urand(2);
        dispatch_data.base_addr = $random(seed);
        dispatch_data.base_rob_id = rob_id_t'(PROD_BASE + urand(8));
        dispatch_data.st_data_ready = urand(2);
        dispatch_data.st_data = $random(seed);
        dispatch_data.st_data_rob_id = rob_id_t'(PROD_BASE + urand(8));
    endtask

    // long low stretches fill the buffers
    task automatic next_ready(inout int hold, output logic ready);
        if (hold > 0) begin
            hold--;
            ready = 1'b0;
        end else if (urand(40) == 0) begin
            hold = 8 + urand(16);
            ready = 1'b0;
        end else begin
            ready = (urand(4) != 0);
        end
    endtask

    task automatic drive_random();
        rob_id_t alu_tag;
        if (!dispatch_valid || disp_taken) begin
            new_dispatch();
        end
        alu_tag = rob_id_t'(PROD_BASE + urand(8));
        alu_broadcast.valid = urand(2);
        alu_broadcast.rob_id = alu_tag;
        alu_broadcast.reg_data = $random(seed);
        // never the same tag on both buses
        ld_broadcast.valid = urand(2);
        ld_broadcast.rob_id = alu_tag ^ rob_id_t'(1 + urand(7));
        ld_broadcast.reg_data = $random(seed);
        next_ready(ld_hold, ld_req_ready);
        next_ready(st_hold, st_req_ready);
        fetch_redirect_valid = (urand(250) == 0);
    endtask

    task automatic drive_drain(input int cyc);
        dispatch_valid = 1'b0;
        fetch_redirect_valid = 1'b0;
        ld_req_ready = 1'b1;
        st_req_ready = 1'b1;
        alu_broadcast.valid = 1'b1;
        alu_broadcast.rob_id = rob_id_t'(PROD_BASE + cyc % 8);
        alu_broadcast.reg_data = $random(seed);
        ld_broadcast.valid = 1'b1;
        ld_broadcast.rob_id = rob_id_t'(PROD_BASE + (cyc + 4) % 8);
        ld_broadcast.reg_data = $random(seed);
    endtask

    initial begin
        seed = 32'h9df3_6672;
        value_errors = 0;
        other_errors = 0;
        next_tag = 0;
        ld_hold = 0;
        st_hold = 0;
        disp_taken = 1'b0;
        flush_prev = 1'b1;
        rst_n = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_data = '0;
        alu_broadcast = '0;
        ld_broadcast = '0;
        fetch_redirect_valid = 1'b0;
        ld_req_ready = 1'b0;
        st_req_ready = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
            @(posedge clk);
            #1 drive_random();
        end
        // drain with everything resolved and no back-pressure
        wait_cycles = 0;
        do begin
            @(posedge clk);
            #1 drive_drain(wait_cycles);
            wait_cycles++;
        end while (model_count(1'b0) != 0 && wait_cycles < DRAIN_TIMEOUT);
        check_cond(model_count(1'b0) == 0,
                   $sformatf("drain did not finish within %0d cycles", DRAIN_TIMEOUT));
        for (int t = 0; t < N_TAGS; t++) begin
            check_cond(!m_valid[t],
                       $sformatf("tag %0d was dispatched but never requested", t));
        end
        $display("value errors: %0d, other failures: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: load_store_issue.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsq_shift_queue.sv
rtl/load_buffer.sv
rtl/store_buffer.sv
rtl/load_store_issue.sv
dv/load_store_issue_tb.sv

// File: Bender.yml
package:
  name: load_store_issue

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsu_pkg.sv
      - rtl/lsq_shift_queue.sv
      - rtl/load_buffer.sv
      - rtl/store_buffer.sv
      - rtl/load_store_issue.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - dv/load_store_issue_tb.sv
